/* hdl/axi_rd_pkg.sv */
// AXI read join channel types
package axi_rd_pkg;

  // ID widths on both sides of the join
  // Upstream ports carry the narrow ID
  localparam int unsigned id_width_slv = 4;
  // Downstream port carries the wide ID
  localparam int unsigned id_width_mst = 5;
  // Prefix bits that name the upstream port
  localparam int unsigned pre_id_width = id_width_mst - id_width_slv;

  // Payload widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;

  // AR channel, upstream side
  // ID sits in the top bits so narrowing drops the prefix
  typedef struct packed {
    logic [id_width_slv-1:0] id;
    logic [addr_width-1:0]   addr;
    // Beats minus one
    logic [7:0]              len;
    // Bytes per beat, log2
    logic [2:0]              size;
  } ar_slv_t;

  // AR channel, downstream side
  typedef struct packed {
    logic [id_width_mst-1:0] id;
    logic [addr_width-1:0]   addr;
    logic [7:0]              len;
    logic [2:0]              size;
  } ar_mst_t;

  // R channel, upstream side
  typedef struct packed {
    logic [id_width_slv-1:0] id;
    logic [data_width-1:0]   data;
    // OKAY, EXOKAY, SLVERR or DECERR
    logic [1:0]              resp;
    // Final beat of the burst
    logic                    last;
  } r_slv_t;

  // R channel, downstream side
  // Top ID bit names the upstream port
  typedef struct packed {
    logic [id_width_mst-1:0] id;
    logic [data_width-1:0]   data;
    logic [1:0]              resp;
    logic                    last;
  } r_mst_t;

endpackage

/* hdl/axi_id_prepend.sv */
// AXI read ID prepend
`timescale 1ns/1ps

module axi_id_prepend #(
  // Prefix put in front of every AR ID of this port
  parameter logic [axi_rd_pkg::pre_id_width-1:0] pre_id = '0
) (
  // Upstream side, narrow IDs
  input  axi_rd_pkg::ar_slv_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  output axi_rd_pkg::r_slv_t  slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  // Downstream side, wide IDs
  output axi_rd_pkg::ar_mst_t mst_ar_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  input  axi_rd_pkg::r_mst_t  mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  import axi_rd_pkg::*;

  // AR widening
  // Prefix goes on top, original ID below it
  assign mst_ar_o.id   = {pre_id, slv_ar_i.id};
  assign mst_ar_o.addr = slv_ar_i.addr;
  assign mst_ar_o.len  = slv_ar_i.len;
  assign mst_ar_o.size = slv_ar_i.size;

  // R narrowing
  // Keep only the low ID bits, prefix is dropped
  assign slv_r_o.id   = mst_r_i.id[id_width_slv-1:0];
  assign slv_r_o.data = mst_r_i.data;
  assign slv_r_o.resp = mst_r_i.resp;
  assign slv_r_o.last = mst_r_i.last;

  // Handshakes pass straight through
  assign mst_ar_valid_o = slv_ar_valid_i;
  assign slv_ar_ready_o = mst_ar_ready_i;
  assign slv_r_valid_o  = mst_r_valid_i;
  assign mst_r_ready_o  = slv_r_ready_i;

endmodule

/* hdl/axi_rd_mux.sv */
// AXI read two-to-one multiplexer
`timescale 1ns/1ps

module axi_rd_mux (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Input port 0
  input  axi_rd_pkg::ar_mst_t in0_ar_i,
  input  logic                in0_ar_valid_i,
  output logic                in0_ar_ready_o,
  output axi_rd_pkg::r_mst_t  in0_r_o,
  output logic                in0_r_valid_o,
  input  logic                in0_r_ready_i,
  // Input port 1
  input  axi_rd_pkg::ar_mst_t in1_ar_i,
  input  logic                in1_ar_valid_i,
  output logic                in1_ar_ready_o,
  output axi_rd_pkg::r_mst_t  in1_r_o,
  output logic                in1_r_valid_o,
  input  logic                in1_r_ready_i,
  // Shared output port
  output axi_rd_pkg::ar_mst_t out_ar_o,
  output logic                out_ar_valid_o,
  input  logic                out_ar_ready_i,
  input  axi_rd_pkg::r_mst_t  out_r_i,
  input  logic                out_r_valid_i,
  output logic                out_r_ready_o
);

  import axi_rd_pkg::*;

  // Favored port, or the held port while locked
  logic rr_q;
  // Set while a granted AR waits on the output
  logic lock_q;
  // Current AR grant, 1 selects port 1
  logic ar_gnt;
  // R destination from the ID prefix
  logic r_sel;

  // AR arbitration
  // Locked grant wins, then pointer on contention, else the lone requester
  always_comb begin
    if (lock_q || (in0_ar_valid_i && in1_ar_valid_i)) begin
      ar_gnt = rr_q;
    end else begin
      ar_gnt = in1_ar_valid_i;
    end
  end

  // AR payload and valid from the granted port
  always_comb begin
    if (ar_gnt) begin
      out_ar_o       = in1_ar_i;
      out_ar_valid_o = in1_ar_valid_i;
    end else begin
      out_ar_o       = in0_ar_i;
      out_ar_valid_o = in0_ar_valid_i;
    end
  end

  // Only the granted port sees the output ready
  assign in0_ar_ready_o = out_ar_ready_i & ~ar_gnt;
  assign in1_ar_ready_o = out_ar_ready_i & ar_gnt;

  // Pointer and lock
  // Transfer: favor the other port next and release the lock
  // Stall: remember the granted port and hold it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q   <= 1'b0;
      lock_q <= 1'b0;
    end else if (out_ar_valid_i_hs()) begin
      rr_q   <= ~ar_gnt;
      lock_q <= 1'b0;
    end else if (out_ar_valid_o) begin
      rr_q   <= ar_gnt;
      lock_q <= 1'b1;
    end
  end

  // AR transfer on the output this cycle
  function automatic logic out_ar_valid_i_hs();
    return out_ar_valid_o & out_ar_ready_i;
  endfunction

  // R routing
  // Top ID bit carries the prefix of the originating port
  assign r_sel = out_r_i.id[id_width_mst-1];

  // Payload fans out to both, valid only to the addressed one
  assign in0_r_o       = out_r_i;
  assign in1_r_o       = out_r_i;
  assign in0_r_valid_o = out_r_valid_i & ~r_sel;
  assign in1_r_valid_o = out_r_valid_i & r_sel;

  // Ready comes back from the addressed port
  assign out_r_ready_o = r_sel ? in1_r_ready_i : in0_r_ready_i;

endmodule

/* hdl/axi_ar_slice.sv */
// AXI AR register slice
`timescale 1ns/1ps

module axi_ar_slice (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream side
  input  axi_rd_pkg::ar_mst_t in_ar_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  // Downstream side
  output axi_rd_pkg::ar_mst_t out_ar_o,
  output logic                out_valid_o,
  input  logic                out_ready_i
);

  import axi_rd_pkg::*;

  // Main stage drives the output
  ar_mst_t main_q;
  logic    main_valid_q;
  // Spill stage catches the beat that arrives during a stall
  ar_mst_t spill_q;
  logic    spill_valid_q;
  // Input transfer
  logic    in_hs;
  // Main stage free to take a new entry
  logic    main_load;

  // Ready only drops when both stages hold an entry
  assign in_ready_o = ~spill_valid_q;
  assign in_hs      = in_valid_i & in_ready_o;
  // Main empties or hands its entry off this cycle
  assign main_load  = ~main_valid_q | out_ready_i;

  // Stage occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else begin
      if (main_load) begin
        // Spill entry is older, so it moves first
        main_valid_q  <= spill_valid_q | in_hs;
        spill_valid_q <= 1'b0;
      end else if (in_hs) begin
        // Main is stalled, new beat parks in spill
        spill_valid_q <= 1'b1;
      end
    end
  end

  // Payload stages
  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_q <= spill_valid_q ? spill_q : in_ar_i;
    end
    if (!main_load && in_hs) begin
      spill_q <= in_ar_i;
    end
  end

  // Oldest entry always sits in main
  assign out_ar_o    = main_q;
  assign out_valid_o = main_valid_q;

endmodule

/* hdl/axi_rd_join.sv */
// AXI read channel join
`timescale 1ns/1ps

module axi_rd_join (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream port 0
  input  axi_rd_pkg::ar_slv_t s0_ar_i,
  input  logic                s0_ar_valid_i,
  output logic                s0_ar_ready_o,
  output axi_rd_pkg::r_slv_t  s0_r_o,
  output logic                s0_r_valid_o,
  input  logic                s0_r_ready_i,
  // Upstream port 1
  input  axi_rd_pkg::ar_slv_t s1_ar_i,
  input  logic                s1_ar_valid_i,
  output logic                s1_ar_ready_o,
  output axi_rd_pkg::r_slv_t  s1_r_o,
  output logic                s1_r_valid_o,
  input  logic                s1_r_ready_i,
  // Downstream port
  output axi_rd_pkg::ar_mst_t m_ar_o,
  output logic                m_ar_valid_o,
  input  logic                m_ar_ready_i,
  input  axi_rd_pkg::r_mst_t  m_r_i,
  input  logic                m_r_valid_i,
  output logic                m_r_ready_o
);

  import axi_rd_pkg::*;

  // Port 0 after ID widening
  ar_mst_t p0_ar;
  logic    p0_ar_valid;
  logic    p0_ar_ready;
  r_mst_t  p0_r;
  logic    p0_r_valid;
  logic    p0_r_ready;
  // Port 1 after ID widening
  ar_mst_t p1_ar;
  logic    p1_ar_valid;
  logic    p1_ar_ready;
  r_mst_t  p1_r;
  logic    p1_r_valid;
  logic    p1_r_ready;
  // Arbitrated AR into the slice
  ar_mst_t mux_ar;
  logic    mux_ar_valid;
  logic    mux_ar_ready;

  // Prefix 0 for port 0
  axi_id_prepend #(
    .pre_id (pre_id_width'(0))
  ) u_prepend_0 (
    .slv_ar_i       (s0_ar_i),
    .slv_ar_valid_i (s0_ar_valid_i),
    .slv_ar_ready_o (s0_ar_ready_o),
    .slv_r_o        (s0_r_o),
    .slv_r_valid_o  (s0_r_valid_o),
    .slv_r_ready_i  (s0_r_ready_i),
    .mst_ar_o       (p0_ar),
    .mst_ar_valid_o (p0_ar_valid),
    .mst_ar_ready_i (p0_ar_ready),
    .mst_r_i        (p0_r),
    .mst_r_valid_i  (p0_r_valid),
    .mst_r_ready_o  (p0_r_ready)
  );

  // Prefix 1 for port 1
  axi_id_prepend #(
    .pre_id (pre_id_width'(1))
  ) u_prepend_1 (
    .slv_ar_i       (s1_ar_i),
    .slv_ar_valid_i (s1_ar_valid_i),
    .slv_ar_ready_o (s1_ar_ready_o),
    .slv_r_o        (s1_r_o),
    .slv_r_valid_o  (s1_r_valid_o),
    .slv_r_ready_i  (s1_r_ready_i),
    .mst_ar_o       (p1_ar),
    .mst_ar_valid_o (p1_ar_valid),
    .mst_ar_ready_i (p1_ar_ready),
    .mst_r_i        (p1_r),
    .mst_r_valid_i  (p1_r_valid),
    .mst_r_ready_o  (p1_r_ready)
  );

  // Round-robin AR, R routed back by prefix
  axi_rd_mux u_mux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in0_ar_i       (p0_ar),
    .in0_ar_valid_i (p0_ar_valid),
    .in0_ar_ready_o (p0_ar_ready),
    .in0_r_o        (p0_r),
    .in0_r_valid_o  (p0_r_valid),
    .in0_r_ready_i  (p0_r_ready),
    .in1_ar_i       (p1_ar),
    .in1_ar_valid_i (p1_ar_valid),
    .in1_ar_ready_o (p1_ar_ready),
    .in1_r_o        (p1_r),
    .in1_r_valid_o  (p1_r_valid),
    .in1_r_ready_i  (p1_r_ready),
    .out_ar_o       (mux_ar),
    .out_ar_valid_o (mux_ar_valid),
    .out_ar_ready_i (mux_ar_ready),
    .out_r_i        (m_r_i),
    .out_r_valid_i  (m_r_valid_i),
    .out_r_ready_o  (m_r_ready_o)
  );

  // Registers the downstream AR, cuts the grant path
  axi_ar_slice u_slice (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_ar_i     (mux_ar),
    .in_valid_i  (mux_ar_valid),
    .in_ready_o  (mux_ar_ready),
    .out_ar_o    (m_ar_o),
    .out_valid_o (m_ar_valid_o),
    .out_ready_i (m_ar_ready_i)
  );

endmodule

/* test/axi_rd_join_properties.sv */
// AXI read join protocol checks
`timescale 1ns/1ps

module axi_rd_join_properties (
  input logic                clk_i,
  input logic                rst_n_i,
  input axi_rd_pkg::ar_mst_t m_ar_o,
  input logic                m_ar_valid_o,
  input logic                m_ar_ready_i,
  input logic                s0_r_valid_o,
  input logic                s1_r_valid_o
);

  // Failed assertions, read by the testbench
  int fail_cnt = 0;

  // Stalled AR holds valid and payload
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_o)))
    else begin
      $error("m_ar valid or payload changed while stalled");
      fail_cnt++;
    end

  // An R beat goes to one port only
  r_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(s0_r_valid_o && s1_r_valid_o))
    else begin
      $error("R valid high on both upstream ports");
      fail_cnt++;
    end

  // No request leaves during reset
  ar_reset: assert property (@(posedge clk_i) !rst_n_i |-> !m_ar_valid_o)
    else begin
      $error("m_ar valid high during reset");
      fail_cnt++;
    end

endmodule

bind axi_rd_join axi_rd_join_properties u_properties (.*);

/* test/tb_axi_rd_join.sv */
// AXI read join testbench
`timescale 1ns/1ps

module tb_axi_rd_join;

  import axi_rd_pkg::*;

  localparam int max_cycles = 4000;

  logic clk_i, rst_n_i;
  ar_slv_t s_ar [2];
  logic s_ar_valid [2], s_ar_ready [2];
  r_slv_t s_r [2];
  logic s_r_valid [2], s_r_ready [2];
  ar_mst_t m_ar;
  logic m_ar_valid, m_ar_ready;
  r_mst_t m_r;
  logic m_r_valid, m_r_ready;

  // Test control and bookkeeping
  int phase = 0, goal = 0, cycles = 0, err_val = 0, err_proto = 0;
  int target [2] = '{0, 0};
  int issued [2] = '{0, 0};
  int rsp_cnt [2] = '{0, 0};
  int fair_cnt = 0;
  logic last_pfx;
  string test_name = "reset";
  logic [31:0] lfsr_q = 32'h5049;
  // Expected m_ar requests per origin port, in issue order
  ar_mst_t exp_ar [2][$];
  // IDs the slave still owes a response
  logic [id_width_mst-1:0] slv_q [$];

  axi_rd_join u_dut (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .s0_ar_i (s_ar[0]), .s0_ar_valid_i (s_ar_valid[0]), .s0_ar_ready_o (s_ar_ready[0]),
    .s0_r_o (s_r[0]), .s0_r_valid_o (s_r_valid[0]), .s0_r_ready_i (s_r_ready[0]),
    .s1_ar_i (s_ar[1]), .s1_ar_valid_i (s_ar_valid[1]), .s1_ar_ready_o (s_ar_ready[1]),
    .s1_r_o (s_r[1]), .s1_r_valid_o (s_r_valid[1]), .s1_r_ready_i (s_r_ready[1]),
    .m_ar_o (m_ar), .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_r_i (m_r), .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per random bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Downstream AR carries the port index above the upstream ID
  function automatic ar_mst_t ref_ar(input ar_slv_t a, input logic k);
    ar_mst_t e;
    e.id   = {k, a.id};
    e.addr = a.addr;
    e.len  = a.len;
    e.size = a.size;
    return e;
  endfunction

  // Top ID bit names the port, the rest of the beat is unchanged
  function automatic r_slv_t ref_r(input r_mst_t b, output logic port);
    r_slv_t e;
    port   = b.id[id_width_mst-1];
    e.id   = b.id[id_width_slv-1:0];
    e.data = b.data;
    e.resp = b.resp;
    e.last = b.last;
    return e;
  endfunction

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Upstream masters, random gaps only in the last phase
  for (genvar k = 0; k < 2; k++) begin : g_master
    always @(posedge clk_i) begin : p_issue
      logic [31:0] go, rdy, addr, misc;
      if (!rst_n_i) begin
        s_ar_valid[k] <= 1'b0;
        s_r_ready[k]  <= 1'b0;
      end else begin
        if (s_ar_valid[k] && s_ar_ready[k]) begin
          exp_ar[k].push_back(ref_ar(s_ar[k], 1'(k)));
        end
        take_bits(1, go);
        take_bits(1, rdy);
        s_r_ready[k] <= (phase == 4) ? rdy[0] : 1'b1;
        if (!s_ar_valid[k] || s_ar_ready[k]) begin
          if (issued[k] < target[k] && (phase != 4 || go[0])) begin
            take_bits(32, addr);
            take_bits(15, misc);
            s_ar[k] <= '{id: misc[14:11], addr: addr, len: misc[10:3], size: misc[2:0]};
            s_ar_valid[k] <= 1'b1;
            issued[k] <= issued[k] + 1;
          end else begin
            s_ar_valid[k] <= 1'b0;
          end
        end
      end
    end
  end

  // Downstream slave, one last beat per request in arrival order
  always @(posedge clk_i) begin : p_slave
    logic [31:0] stall, dat, rsp;
    if (!rst_n_i) begin
      m_ar_ready <= 1'b0;
      m_r_valid  <= 1'b0;
    end else begin
      if (m_ar_valid && m_ar_ready) begin
        slv_q.push_back(m_ar.id);
      end
      take_bits(1, stall);
      m_ar_ready <= (phase == 4) ? stall[0] : 1'b1;
      if (!m_r_valid || m_r_ready) begin
        if (slv_q.size() > 0) begin
          take_bits(32, dat);
          take_bits(2, rsp);
          m_r <= '{id: slv_q.pop_front(), data: dat, resp: rsp[1:0], last: 1'b1};
          m_r_valid <= 1'b1;
        end else begin
          m_r_valid <= 1'b0;
        end
      end
    end
  end

  // Compare every downstream AR and every R beat with the reference
  always @(posedge clk_i) begin : p_compare
    ar_mst_t exp_a;
    r_slv_t  exp_r;
    logic    pfx, port;
    if (phase == 0) begin
      if (m_ar_valid || s_r_valid[0] || s_r_valid[1]) begin
        err_proto++;
        $display("valid output high during or right after reset");
      end
    end else begin
      if (m_ar_valid && m_ar_ready) begin
        pfx = m_ar.id[id_width_mst-1];
        if (exp_ar[pfx].size() == 0) begin
          err_proto++;
          $display("%s: m_ar request from port %0d that was never issued", test_name, pfx);
        end else begin
          exp_a = exp_ar[pfx].pop_front();
          if (m_ar !== exp_a) begin
            err_val++;
            $display("mismatch %s: expected %h, actual %h", test_name, exp_a, m_ar);
          end
        end
        // Both ports always request here, so grants must alternate
        if (phase == 3) begin
          if (fair_cnt > 0 && pfx == last_pfx) begin
            err_proto++;
            $display("%s: port %0d granted twice in a row", test_name, pfx);
          end
          fair_cnt++;
        end
        last_pfx = pfx;
      end
      if (m_r_valid && m_r_ready) begin
        exp_r = ref_r(m_r, port);
        // Downstream beat must be taken by the addressed port in the same cycle
        if (!s_r_valid[port] || !s_r_ready[port] || s_r_valid[~port]) begin
          err_proto++;
          $display("%s: R beat not accepted at port %0d or seen on the wrong port",
                   test_name, port);
        end else if (s_r[port] !== exp_r) begin
          err_val++;
          $display("mismatch %s: expected %h, actual %h", test_name, exp_r, s_r[port]);
        end
        rsp_cnt[port]++;
      end else if ((s_r_valid[0] && s_r_ready[0]) || (s_r_valid[1] && s_r_ready[1])) begin
        err_proto++;
        $display("%s: upstream R beat without a downstream beat", test_name);
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles in %s", cycles, test_name);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Adds requests per port and waits for all responses
  task automatic run_phase(input int ph, input string name, input int n0, input int n1);
    test_name = name;
    @(posedge clk_i);
    phase <= ph;
    target[0] <= target[0] + n0;
    target[1] <= target[1] + n1;
    goal = goal + n0 + n1;
    while (rsp_cnt[0] + rsp_cnt[1] < goal) @(posedge clk_i);
  endtask

  initial begin
    rst_n_i <= 1'b0;
    s_ar[0] <= '0;
    s_ar[1] <= '0;
    s_ar_valid[0] <= 1'b0;
    s_ar_valid[1] <= 1'b0;
    s_r_ready[0] <= 1'b0;
    s_r_ready[1] <= 1'b0;
    m_ar_ready <= 1'b0;
    m_r <= '0;
    m_r_valid <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle cycles after reset stay in the reset check
    repeat (4) @(posedge clk_i);
    run_phase(1, "port0_only", 64, 0);
    run_phase(2, "port1_only", 0, 64);
    run_phase(3, "fairness", 64, 64);
    run_phase(4, "backpressure", 64, 64);
    repeat (4) @(posedge clk_i);
    for (int k = 0; k < 2; k++) begin
      if (rsp_cnt[k] != issued[k] || exp_ar[k].size() != 0) begin
        err_proto++;
        $display("port %0d issued %0d reads but got %0d responses", k, issued[k], rsp_cnt[k]);
      end
    end
    $display("errors: %0d mismatch, %0d protocol, %0d assertion",
             err_val, err_proto, u_dut.u_properties.fail_cnt);
    if (err_val + err_proto + u_dut.u_properties.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/axi_rd_pkg.sv
hdl/axi_id_prepend.sv
hdl/axi_rd_mux.sv
hdl/axi_ar_slice.sv
hdl/axi_rd_join.sv
test/axi_rd_join_properties.sv
test/tb_axi_rd_join.sv
